/* project.f */
+incdir+rtl
+incdir+test
rtl/f100_pkg.sv
rtl/f100_sequencer.sv
rtl/f100_program_counter.sv
rtl/f100_operand_path.sv
rtl/f100_alu.sv
rtl/f100_core.sv
test/tb_f100_core.sv

/* test/tb_f100_model.svh */
// Instruction-set model of the F100 core for the testbench.
// Runs the program held in model_mem and predicts writes, accum, flags and PC.

function automatic word_t model_read(input word_t a);
  return model_mem.exists(a) ? model_mem[a] : blank_word(a);
endfunction

function automatic logic opcode_kept(input logic [3:0] op);
  return op inside {`F100_OP_LDA, `F100_OP_ADD, `F100_OP_SUB, `F100_OP_AND,
                    `F100_OP_NEQ, `F100_OP_STO, `F100_OP_JMP};
endfunction

// Operand instructions. SUB takes the accumulator from the operand.
task automatic model_apply(input logic [3:0] op, input word_t d);
  logic [`F100_WORD_W:0] r;
  logic                  a_sign;
  a_sign = exp_accum[msb];
  case (op)
    `F100_OP_LDA: r = {1'b0, d};
    `F100_OP_ADD: r = {1'b0, d} + {1'b0, exp_accum};
    `F100_OP_SUB: r = {1'b0, d} - {1'b0, exp_accum};
    `F100_OP_AND: r = {1'b0, d & exp_accum};
    default:      r = {1'b0, d ^ exp_accum};
  endcase
  if (op == `F100_OP_ADD)
    exp_flags.v = (a_sign == d[msb]) && (r[msb] != a_sign);
  else if (op == `F100_OP_SUB)
    exp_flags.v = (a_sign != d[msb]) && (r[msb] == a_sign);
  exp_flags.c = r[`F100_WORD_W];
  exp_flags.s = r[msb];
  exp_flags.z = (r[msb:0] == '0);
  exp_accum = r[msb:0];
endtask

task automatic run_model();
  word_t    pc;
  word_t    ir;
  word_t    ea;
  mem_req_t wr;
  logic     done;
  int       steps;
  pc = `F100_RESET_PC;
  exp_accum = '0;
  exp_flags = '0;
  exp_writes.delete();
  done = 1'b0;
  steps = 0;
  while (!done && steps < 400)
  begin
    ir = model_read(pc);
    pc = pc + 1'b1;
    steps++;
    if (ir[11] || !opcode_kept(ir[15:12]))
      done = 1'b1;
    else
    begin
      // A zero address field means the operand word follows the instruction.
      if (ir[10:0] == '0)
      begin
        ea = pc;
        pc = pc + 1'b1;
      end
      else
        ea = {{(`F100_WORD_W - 11){1'b0}}, ir[10:0]};
      if (ir[15:12] == `F100_OP_JMP)
        pc = ea;
      else if (ir[15:12] == `F100_OP_STO)
      begin
        wr = '{strobe: 1'b1, write: 1'b1, address: ea, wdata: exp_accum};
        exp_writes.push_back(wr);
        model_mem[ea] = exp_accum;
        exp_flags.c = 1'b0;
        exp_flags.s = exp_accum[msb];
        exp_flags.z = (exp_accum == '0);
      end
      else
        model_apply(ir[15:12], model_read(ea));
    end
  end
  exp_pc = pc;
  model_ok = done;
endtask

/* test/tb_f100_core.sv */
// Testbench of the F100 core: clock, reset, memory responder, random
// programs, compare tasks and the test sequence.
`timescale 1ns/100ps
`include "f100_consts.svh"

module tb_f100_core;

  import f100_pkg::*;

  localparam int msb = `F100_WORD_W - 1;
  localparam int k_lda = 0;
  localparam int k_arith = 1;
  localparam int k_logic = 2;
  localparam int k_store = 3;
  localparam int k_jump = 4;
  localparam int halt_limit = 2000;

  logic         raw_clk = 1'b0;
  logic         button_reset;
  word_t        mem_rdata = '0;
  mem_req_t     mem_req;
  core_status_t status;

  word_t    mem [word_t];
  word_t    model_mem [word_t];
  mem_req_t write_log [$];
  mem_req_t exp_writes [$];
  word_t    exp_accum;
  word_t    exp_pc;
  flags_t   exp_flags;
  logic     model_ok;
  int       strobe_count = 0;
  int       test_errors;
  int       tests_run;
  int       tests_failed;
  word_t    wp;
  word_t    next_seg;

  f100_core u_dut
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_rdata    (mem_rdata),
    .mem_req      (mem_req),
    .status       (status)
  );

  always #10 raw_clk = ~raw_clk;

  // Long-mode bit set, so a stray fetch halts the core.
  function automatic word_t blank_word(input word_t a);
    return a | 16'h0800;
  endfunction

  `include "tb_f100_model.svh"

  // Memory with one cycle read latency.
  always @(posedge raw_clk)
  begin
    if (mem_req.strobe)
    begin
      strobe_count++;
      if (mem_req.write)
      begin
        mem[mem_req.address] = mem_req.wdata;
        write_log.push_back(mem_req);
      end
      else
        mem_rdata <= mem.exists(mem_req.address) ? mem[mem_req.address]
                                                 : blank_word(mem_req.address);
    end
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flags(input string name, input flags_t exp, input flags_t act);
    if (exp !== act)
    begin
      $display("MISMATCH %s expected csvz=%b actual csvz=%b", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_write(input string name, input mem_req_t exp, input mem_req_t act);
    if (exp !== act)
    begin
      $display("MISMATCH %s expected s=%b w=%b a=%h d=%h actual s=%b w=%b a=%h d=%h",
               name, exp.strobe, exp.write, exp.address, exp.wdata,
               act.strobe, act.write, act.address, act.wdata);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0)
      $display("PASS %s", name);
    else
    begin
      tests_failed++;
      $display("FAIL %s with %0d errors", name, test_errors);
    end
  endtask

  task automatic emit(input word_t w);
    mem[wp] = w;
    wp = wp + 1'b1;
  endtask

  task automatic emit_op(input logic [3:0] op);
    if ($urandom_range(1, 0) == 0)
    begin
      emit({op, 1'b0, 11'h000});
      emit(word_t'($urandom()));
    end
    else
      emit({op, 1'b0, 11'($urandom_range(255, 1))});
  endtask

  function automatic logic [3:0] pick_op(input int kind);
    int r;
    r = $urandom_range(5, 0);
    case (kind)
      k_lda:   return `F100_OP_LDA;
      k_arith: return (r == 0) ? `F100_OP_LDA : (r[0] ? `F100_OP_ADD : `F100_OP_SUB);
      k_logic: return (r == 0) ? `F100_OP_ADD : (r[0] ? `F100_OP_AND : `F100_OP_NEQ);
      k_store:
        case (r)
          0:       return `F100_OP_LDA;
          1:       return `F100_OP_ADD;
          2:       return `F100_OP_SUB;
          3:       return `F100_OP_AND;
          4:       return `F100_OP_NEQ;
          default: return `F100_OP_STO;
        endcase
      default:
        case (r)
          0:       return `F100_OP_LDA;
          1:       return `F100_OP_ADD;
          2:       return `F100_OP_NEQ;
          3:       return `F100_OP_STO;
          default: return `F100_OP_JMP;
        endcase
    endcase
  endfunction

  task automatic build_program(input int kind);
    logic [3:0] op;
    int         n;
    int         i;
    int         a;
    mem.delete();
    for (a = 1; a < 256; a++)
      mem[word_t'(a)] = word_t'($urandom());
    wp = `F100_RESET_PC;
    next_seg = 16'h0100 + word_t'($urandom_range(15, 0));
    n = $urandom_range(20, 12);
    emit_op(`F100_OP_LDA);
    for (i = 1; i < n; i++)
    begin
      op = pick_op(kind);
      if (op == `F100_OP_JMP && $urandom_range(1, 0) == 1)
      begin
        // Short jumps reach low memory only; each opens a segment above the last.
        emit({op, 1'b0, next_seg[10:0]});
        repeat ($urandom_range(3, 1))
          emit({`F100_OP_STO, 1'b0, 11'($urandom_range(255, 1))});
        wp = next_seg;
        next_seg = next_seg + 16'd64;
      end
      else if (op == `F100_OP_JMP)
        emit({op, 1'b0, 11'h000});
      else
        emit_op(op);
    end
    emit(`F100_HALT_WORD);
  endtask

  // Ten reset cycles, with memory and model prepared while the core is held.
  task automatic reset_with_program(input int kind);
    int i;
    @(posedge raw_clk);
    button_reset <= 1'b0;
    @(posedge raw_clk);
    @(negedge raw_clk);
    build_program(kind);
    model_mem = mem;
    run_model();
    write_log.delete();
    for (i = 0; i < 9; i++)
      @(posedge raw_clk);
    button_reset <= 1'b1;
  endtask

  task automatic run_reset_test();
    mem_req_t exp_req;
    int       n;
    test_errors = 0;
    reset_with_program(k_lda);
    @(negedge raw_clk);
    check_word("reset pc", `F100_RESET_PC, status.pc);
    check_word("reset accum", '0, status.accum);
    check_flags("reset flags", '0, status.flags);
    if (status.halted)
    begin
      $display("Core reports halted right after reset");
      test_errors++;
    end
    n = 0;
    while (!mem_req.strobe && n < 20)
    begin
      @(negedge raw_clk);
      n++;
    end
    if (!mem_req.strobe)
    begin
      $display("Timeout in test reset: no memory strobe after reset");
      test_errors++;
    end
    else
    begin
      exp_req = '{strobe: 1'b1, write: 1'b0, address: `F100_RESET_PC, wdata: 16'h0000};
      check_write("reset first request", exp_req, mem_req);
      check_word("reset first strobe delay", 16'd1, word_t'(n));
    end
    finish_test("reset");
  endtask

  task automatic run_program_test(input string name, input int kind);
    int   cycles;
    int   i;
    int   strobes_at_halt;
    logic stayed;
    test_errors = 0;
    reset_with_program(kind);
    if (!model_ok)
    begin
      $display("Model did not reach a halt in test %s", name);
      test_errors++;
    end
    cycles = 0;
    @(negedge raw_clk);
    while (!status.halted && cycles < halt_limit)
    begin
      @(negedge raw_clk);
      cycles++;
    end
    if (!status.halted)
    begin
      $display("Timeout in test %s: core did not halt in %0d cycles", name, halt_limit);
      test_errors++;
    end
    else
    begin
      check_word({name, " pc"}, exp_pc, status.pc);
      check_word({name, " accum"}, exp_accum, status.accum);
      check_flags({name, " flags"}, exp_flags, status.flags);
      check_word({name, " write count"}, word_t'(exp_writes.size()),
                 word_t'(write_log.size()));
      for (i = 0; i < exp_writes.size() && i < write_log.size(); i++)
        check_write($sformatf("%s write %0d", name, i), exp_writes[i], write_log[i]);
      strobes_at_halt = strobe_count;
      stayed = 1'b1;
      for (i = 0; i < 50; i++)
      begin
        @(negedge raw_clk);
        if (!status.halted)
          stayed = 1'b0;
      end
      if (!stayed)
      begin
        $display("Core left the halted state without reset in test %s", name);
        test_errors++;
      end
      check_word({name, " strobes after halt"}, 16'd0,
                 word_t'(strobe_count - strobes_at_halt));
    end
    finish_test(name);
  endtask

  initial
  begin
    int round;
    button_reset = 1'b0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(32'hab4e7ad4));
    run_reset_test();
    for (round = 0; round < 3; round++)
    begin
      run_program_test($sformatf("lda_%0d", round), k_lda);
      run_program_test($sformatf("add_sub_%0d", round), k_arith);
      run_program_test($sformatf("and_neq_%0d", round), k_logic);
      run_program_test($sformatf("store_mix_%0d", round), k_store);
      run_program_test($sformatf("jump_%0d", round), k_jump);
    end
    $display("Tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* rtl/f100_core.sv */
// Top level of the F100 core: sequencer, program counter, operand path
// and ALU, with the memory request and status ports.
`timescale 1ns/100ps

module f100_core
(
  input  logic                   raw_clk,
  input  logic                   button_reset,
  input  f100_pkg::word_t        mem_rdata,
  output f100_pkg::mem_req_t     mem_req,
  output f100_pkg::core_status_t status
);

  import f100_pkg::*;

  instr_t   instr;
  dp_ctrl_t dp_ctrl;
  alu_op_e  alu_op;
  logic     alu_execute;
  logic     pc_inc;
  logic     pc_load;
  logic     mem_strobe;
  logic     halted;
  word_t    pc;
  word_t    ea;
  word_t    data;
  word_t    accum;
  flags_t   flags;

  f100_sequencer u_sequencer
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .instr        (instr),
    .dp_ctrl      (dp_ctrl),
    .alu_op       (alu_op),
    .alu_execute  (alu_execute),
    .pc_inc       (pc_inc),
    .pc_load      (pc_load),
    .mem_strobe   (mem_strobe),
    .halted       (halted)
  );

  // Jump targets come in through ea.
  f100_program_counter u_program_counter
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .inc          (pc_inc),
    .load         (pc_load),
    .load_value   (ea),
    .pc           (pc)
  );

  f100_operand_path u_operand_path
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .ctrl         (dp_ctrl),
    .mem_strobe   (mem_strobe),
    .pc           (pc),
    .accum        (accum),
    .mem_rdata    (mem_rdata),
    .instr        (instr),
    .ea           (ea),
    .data         (data),
    .mem_req      (mem_req)
  );

  f100_alu u_alu
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .op           (alu_op),
    .execute      (alu_execute),
    .data         (data),
    .accum        (accum),
    .flags        (flags)
  );

  assign status = '{halted: halted, pc: pc, accum: accum, flags: flags};

endmodule

/* rtl/f100_alu.sv */
// Accumulator, condition flags and arithmetic/logic unit of the F100 core.
`timescale 1ns/100ps
`include "f100_consts.svh"

module f100_alu
(
  input  logic              raw_clk,
  input  logic              button_reset,
  input  f100_pkg::alu_op_e op,
  input  logic              execute,
  input  f100_pkg::word_t   data,
  output f100_pkg::word_t   accum,
  output f100_pkg::flags_t  flags
);

  import f100_pkg::*;

  localparam int w = `F100_WORD_W;

  // Bit w is the carry, or the borrow on subtract.
  logic [w:0] result;
  logic       add_ovf;
  logic       sub_ovf;

  always_comb
  begin
    case (op)
      load:    result = {1'b0, data};
      add:     result = {1'b0, data} + {1'b0, accum};
      sub:     result = {1'b0, data} - {1'b0, accum};
      and_op:  result = {1'b0, data & accum};
      neq:     result = {1'b0, data ^ accum};
      store:   result = {1'b0, accum};
      default: result = '0;
    endcase
  end

  assign add_ovf = (accum[w-1] == data[w-1]) && (result[w-1] != accum[w-1]);
  assign sub_ovf = (accum[w-1] != data[w-1]) && (result[w-1] == accum[w-1]);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      accum <= '0;
      flags <= '0;
    end
    else if (execute)
    begin
      if (op != store)
        accum <= result[w-1:0];
      flags.z <= (result[w-1:0] == '0);
      flags.s <= result[w-1];
      flags.c <= result[w];
      // V is left alone outside add and subtract.
      if (op == add)
        flags.v <= add_ovf;
      else if (op == sub)
        flags.v <= sub_ovf;
    end
  end

  exec_has_op: assert property (@(posedge raw_clk) disable iff (!button_reset)
    execute |-> op != none);

endmodule

/* rtl/f100_operand_path.sv */
// Instruction, effective address and operand registers of the F100 core,
// and the memory request mux.
`timescale 1ns/100ps
`include "f100_consts.svh"

module f100_operand_path
(
  input  logic                raw_clk,
  input  logic                button_reset,
  input  f100_pkg::dp_ctrl_t  ctrl,
  input  logic                mem_strobe,
  input  f100_pkg::word_t     pc,
  input  f100_pkg::word_t     accum,
  input  f100_pkg::word_t     mem_rdata,
  output f100_pkg::instr_t    instr,
  output f100_pkg::word_t     ea,
  output f100_pkg::word_t     data,
  output f100_pkg::mem_req_t  mem_req
);

  import f100_pkg::*;

  word_t ea_short;

  assign ea_short = {{(`F100_WORD_W - `F100_SHORT_ADDR_W){1'b0}}, instr.addr};

  // A cleared instruction decodes into the halt space.
  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
      instr <= '0;
    else if (ctrl.load_instr)
      instr <= instr_t'(mem_rdata);
  end

  always_ff @(posedge raw_clk)
  begin
    if (ctrl.load_ea_short)
      ea <= ea_short;
    else if (ctrl.load_ea_pc)
      ea <= pc;
    if (ctrl.load_data)
      data <= mem_rdata;
  end

  always_comb
  begin
    mem_req.strobe = mem_strobe;
    mem_req.write = mem_strobe & ctrl.write_mem;
    mem_req.address = ctrl.sel_ea ? ea : pc;
    mem_req.wdata = accum;
  end

  // Stores go to a short address or an immediate slot, never word 0.
  write_addr_nonzero: assert property (@(posedge raw_clk) disable iff (!button_reset)
    mem_req.strobe && mem_req.write |-> mem_req.address != '0);

endmodule

/* rtl/f100_program_counter.sv */
// Program counter of the F100 core with reset address, increment and load.
`timescale 1ns/100ps
`include "f100_consts.svh"

module f100_program_counter
(
  input  logic            raw_clk,
  input  logic            button_reset,
  input  logic            inc,
  input  logic            load,
  input  f100_pkg::word_t load_value,
  output f100_pkg::word_t pc
);

  // Load wins over increment. The sequencer never asks for both.
  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
      pc <= `F100_RESET_PC;
    else if (load)
      pc <= load_value;
    else if (inc)
      pc <= pc + 1'b1;
  end

endmodule

/* rtl/f100_sequencer.sv */
// Instruction cycle FSM of the F100 core: decode, datapath steering,
// memory strobe and halt.
`timescale 1ns/100ps
`include "f100_consts.svh"

module f100_sequencer
(
  input  logic               raw_clk,
  input  logic               button_reset,
  input  f100_pkg::instr_t   instr,
  output f100_pkg::dp_ctrl_t dp_ctrl,
  output f100_pkg::alu_op_e  alu_op,
  output logic               alu_execute,
  output logic               pc_inc,
  output logic               pc_load,
  output logic               mem_strobe,
  output logic               halted
);

  import f100_pkg::*;

  typedef enum logic [3:0] {
    st_start,
    st_fetch,
    st_fetch_wait,
    st_decode,
    st_read,
    st_read_wait,
    st_execute,
    st_store,
    st_jump,
    st_halted
  } state_e;

  state_e state;
  state_e next_state;
  logic   is_jump;
  logic   decodable;
  logic   immediate;

  always_comb
  begin
    case (instr.opcode)
      `F100_OP_LDA: alu_op = load;
      `F100_OP_ADD: alu_op = add;
      `F100_OP_SUB: alu_op = sub;
      `F100_OP_AND: alu_op = and_op;
      `F100_OP_NEQ: alu_op = neq;
      `F100_OP_STO: alu_op = store;
      default:      alu_op = none;
    endcase
  end

  assign is_jump = (instr.opcode == `F100_OP_JMP);

  // Long modes and unknown opcodes fall into the halt space.
  assign decodable = !instr.long_mode && (is_jump || alu_op != none);
  assign immediate = (instr.addr == '0);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
      state <= st_start;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      st_start:      next_state = st_fetch;
      st_fetch:      next_state = st_fetch_wait;
      st_fetch_wait: next_state = st_decode;
      st_decode:
        begin
          if (!decodable)
            next_state = st_halted;
          else if (is_jump)
            next_state = st_jump;
          else if (alu_op == store)
            next_state = st_store;
          else
            next_state = st_read;
        end
      st_read:       next_state = st_read_wait;
      st_read_wait:  next_state = st_execute;
      st_execute:    next_state = st_fetch;
      st_store:      next_state = st_fetch;
      st_jump:       next_state = st_fetch;
      default:       next_state = st_halted;
    endcase
  end

  always_comb
  begin
    dp_ctrl = '0;
    alu_execute = 1'b0;
    pc_inc = 1'b0;
    pc_load = 1'b0;
    mem_strobe = 1'b0;
    case (state)
      st_fetch:
        begin
          mem_strobe = 1'b1;
          pc_inc = 1'b1;
        end
      st_fetch_wait: dp_ctrl.load_instr = 1'b1;
      st_decode:
        begin
          // Immediate operand sits at the PC, so step past it.
          if (decodable && immediate)
          begin
            dp_ctrl.load_ea_pc = 1'b1;
            pc_inc = 1'b1;
          end
          else if (decodable)
            dp_ctrl.load_ea_short = 1'b1;
        end
      st_read:
        begin
          mem_strobe = 1'b1;
          dp_ctrl.sel_ea = 1'b1;
        end
      st_read_wait:  dp_ctrl.load_data = 1'b1;
      st_execute:    alu_execute = 1'b1;
      st_store:
        begin
          mem_strobe = 1'b1;
          dp_ctrl.sel_ea = 1'b1;
          dp_ctrl.write_mem = 1'b1;
          alu_execute = 1'b1;
        end
      st_jump:       pc_load = 1'b1;
      default:       ;
    endcase
  end

  assign halted = (state == st_halted);

  // Only reset takes the core out of halt.
  halt_sticky: assert property (@(posedge raw_clk) halted && button_reset |=> halted);

  pc_ctrl_onehot: assert property (@(posedge raw_clk) disable iff (!button_reset)
    !(pc_inc && pc_load));

endmodule

/* rtl/f100_pkg.sv */
// Shared types of the F100 core: data word, decoded instruction, flags,
// memory request, status port, ALU operation and datapath steering.
`include "f100_consts.svh"

package f100_pkg;

  typedef logic [`F100_WORD_W-1:0] word_t;

  // Bit 11 selects the long modes, which this core does not decode.
  typedef struct packed {
    logic [3:0]                        opcode;
    logic                              long_mode;
    logic [`F100_SHORT_ADDR_W-1:0]     addr;
  } instr_t;

  typedef struct packed {
    logic c;
    logic s;
    logic v;
    logic z;
  } flags_t;

  typedef struct packed {
    logic  strobe;
    logic  write;
    word_t address;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic   halted;
    word_t  pc;
    word_t  accum;
    flags_t flags;
  } core_status_t;

  typedef enum logic [2:0] {
    none,
    load,
    add,
    sub,
    and_op,
    neq,
    store
  } alu_op_e;

  typedef struct packed {
    logic load_instr;
    logic load_ea_short;
    logic load_ea_pc;
    logic load_data;
    logic sel_ea;
    logic write_mem;
  } dp_ctrl_t;

endpackage

/* rtl/f100_consts.svh */
// Word width, opcode values, halt word and reset address of the F100 core.
`ifndef F100_CONSTS_SVH
`define F100_CONSTS_SVH

// Data and address width.
`define F100_WORD_W 16

// First instruction fetch after reset.
`define F100_RESET_PC 16'h2000

// Opcodes in bits 15:12 of the instruction word.
`define F100_OP_LDA 4'h8
`define F100_OP_ADD 4'h9
`define F100_OP_SUB 4'ha
`define F100_OP_AND 4'hc
`define F100_OP_NEQ 4'hd
`define F100_OP_STO 4'h4
`define F100_OP_JMP 4'hf

// Opcode 0 with bits 11:10 set to 01.
`define F100_HALT_WORD 16'h0400

// Width of the short direct address field.
`define F100_SHORT_ADDR_W 11

`endif
